// File: build.f
execPkg.sv
regFile.sv
aluUnit.sv
mulDivUnit.sv
writebackStage.sv
execCore.sv
tbClock.sv
execCore_tb.sv

// File: execCore_tb.sv
`timescale 1ns/1ps
`default_nettype none

module execCore_tb
    import execPkg::*;
;

    localparam int MulLat = DefaultMulLatency;
    localparam int DivLat = DefaultDivLatency;

    logic        clk;
    logic        reset;
    logic        opValid;
    opCodeT      opCode;
    regAddrT     rs;
    regAddrT     rt;
    regAddrT     rd;
    logic [15:0] imm;
    logic        useImm;
    logic        busy;
    logic        wbValid;
    regAddrT     wbReg;
    logic [31:0] wbData;
    logic        excValid;
    causeT       excCause;

    // Reference model state
    logic [31:0] modelRegs [0:31];
    logic [31:0] modelHi;
    logic [31:0] modelLo;
    logic [31:0] pendHi;
    logic [31:0] pendLo;
    int          busyLeft;
    logic        expWbValid;
    regAddrT     expWbReg;
    logic [31:0] expWbData;
    logic        expExcValid;
    causeT       expExcCause;

    logic [31:0] lfsrState = 32'h1b1b_4fda;
    regAddrT     lastRd;
    int          cycleCount;
    int          scheduledLat;

    opCodeT aluOps [14] = '{opAdd, opAddu, opSub, opSubu, opAnd, opOr, opXor, opNor,
                           opSlt, opSltu, opSllv, opSrlv, opSrav, opLui};

    tbClock #(.resetCycles(10)) clkGen (.clk(clk), .reset(reset));

    execCore #(
        .dataWidth(DefaultDataWidth), .mulLatency(MulLat), .divLatency(DivLat)
    ) uut (
        .clk(clk), .reset(reset), .opValid(opValid), .opCode(opCode),
        .rs(rs), .rt(rt), .rd(rd), .imm(imm), .useImm(useImm),
        .busy(busy), .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
        .excValid(excValid), .excCause(excCause)
    );

    // Galois LFSR, one step per bit
    function automatic logic [31:0] randBits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h8020_0003) : (lfsrState >> 1);
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    task automatic compareValue(string name, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic modelAlu(input opCodeT op, input logic [31:0] a, input logic [31:0] b,
                            output logic [31:0] res, output logic ov);
        longint sa;
        longint sb;
        longint wide;
        sa = $signed(a);
        sb = $signed(b);
        ov = 1'b0;
        res = '0;
        case (op)
            opAdd, opAddu: begin
                wide = sa + sb;
                res = wide[31:0];
                ov = (op == opAdd) && (wide > 64'sd2147483647 || wide < -64'sd2147483648);
            end
            opSub, opSubu: begin
                wide = sa - sb;
                res = wide[31:0];
                ov = (op == opSub) && (wide > 64'sd2147483647 || wide < -64'sd2147483648);
            end
            opAnd:  res = a & b;
            opOr:   res = a | b;
            opXor:  res = a ^ b;
            opNor:  res = ~(a | b);
            opSlt:  res = (sa < sb) ? 32'd1 : 32'd0;
            opSltu: res = (a < b) ? 32'd1 : 32'd0;
            opSllv: res = b << a[4:0];
            opSrlv: res = b >> a[4:0];
            opSrav: res = $signed(b) >>> a[4:0];
            opLui:  res = {b[15:0], 16'h0000};
            default: res = '0;
        endcase
    endtask

    // Predicts the outputs of the next cycle
    task automatic predict(logic valid, opCodeT op, regAddrT s, regAddrT t, regAddrT d,
                           logic [15:0] im, logic ui);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic        ov;
        logic [63:0] prod;
        expWbValid = 1'b0;
        expExcValid = 1'b0;
        if (!valid) begin
            return;
        end
        a = modelRegs[s];
        b = ui ? {{16{im[15]}}, im} : modelRegs[t];
        ov = 1'b0;
        if (op inside {opMult, opMultu, opDiv, opDivu}) begin
            busyLeft = (op inside {opDiv, opDivu}) ? DivLat : MulLat;
            if (op == opMult) begin
                prod = longint'($signed(a)) * longint'($signed(b));
            end else if (op == opMultu) begin
                prod = {32'h0, a} * {32'h0, b};
            end else if (b == 0) begin
                prod = {a, 32'hffff_ffff};
            end else if (op == opDiv) begin
                prod = {32'(longint'($signed(a)) % longint'($signed(b))),
                        32'(longint'($signed(a)) / longint'($signed(b)))};
            end else begin
                prod = {a % b, a / b};
            end
            {pendHi, pendLo} = prod;
            return;
        end
        if (op == opMfhi) begin
            res = modelHi;
        end else if (op == opMflo) begin
            res = modelLo;
        end else if (op inside {aluOps}) begin
            modelAlu(op, a, b, res, ov);
        end else begin
            expExcValid = 1'b1;
            expExcCause = causeRI;
            return;
        end
        if (ov) begin
            expExcValid = 1'b1;
            expExcCause = causeOv;
        end else if (d != 0) begin
            expWbValid = 1'b1;
            expWbReg = d;
            expWbData = res;
            modelRegs[d] = res;
        end
    endtask

    task automatic checkOutputs();
        compareValue("wbValid", wbValid, expWbValid);
        if (expWbValid) begin
            compareValue("wbReg", wbReg, expWbReg);
            compareValue("wbData", wbData, expWbData);
        end
        compareValue("excValid", excValid, expExcValid);
        if (expExcValid) begin
            compareValue("excCause", excCause, expExcCause);
        end
        compareValue("busy", busy, busyLeft > 0);
    endtask

    task automatic runCycle(logic valid, opCodeT op, regAddrT s, regAddrT t, regAddrT d,
                            logic [15:0] im, logic ui);
        @(posedge clk);
        opValid <= valid;
        opCode <= op;
        rs <= s;
        rt <= t;
        rd <= d;
        imm <= im;
        useImm <= ui;
        @(negedge clk);
        checkOutputs();
        if (busyLeft > 0) begin
            busyLeft--;
            if (busyLeft == 0) begin
                modelHi = pendHi;
                modelLo = pendLo;
            end
        end
        predict(valid, op, s, t, d, im, ui);
        if (valid && d != 0) begin
            lastRd = d;
        end
    endtask

    task automatic idleCycle();
        runCycle(1'b0, opAnd, 0, 0, 0, 16'h0, 1'b0);
    endtask

    task automatic randomAlu();
        opCodeT  op;
        regAddrT s;
        regAddrT t;
        op = aluOps[randBits(4) % 14];
        s = randBits(1) ? lastRd : regAddrT'(randBits(5));
        t = randBits(1) ? lastRd : regAddrT'(randBits(5));
        runCycle(1'b1, op, s, t, regAddrT'(randBits(5)), randBits(16), randBits(2) == 0);
    endtask

    task automatic waitIdle();
        do begin
            idleCycle();
        end while (busy);
    endtask

    task automatic mulDivCase(opCodeT op, regAddrT s, regAddrT t);
        waitIdle();
        scheduledLat += (op inside {opDiv, opDivu}) ? DivLat : MulLat;
        runCycle(1'b1, op, s, t, 0, 16'h0, 1'b0);
        // ALU keeps issuing under a busy multiply/divide
        repeat (3) randomAlu();
        waitIdle();
        runCycle(1'b1, opMfhi, 0, 0, 5'd7, 16'h0, 1'b0);
        runCycle(1'b1, opMflo, 0, 0, 5'd8, 16'h0, 1'b0);
    endtask

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > 400 + scheduledLat) begin
            $display("Timeout: the run went past %0d cycles", 400 + scheduledLat);
            $display("Simulation failed");
            $fatal(1, "Timeout");
        end
    end

    initial begin
        opValid = 1'b0;
        opCode = opAnd;
        rs = '0;
        rt = '0;
        rd = '0;
        imm = '0;
        useImm = 1'b0;
        cycleCount = 0;
        scheduledLat = 0;
        busyLeft = 0;
        lastRd = 5'd1;
        modelHi = '0;
        modelLo = '0;
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        expWbValid = 1'b0;
        expExcValid = 1'b0;

        @(negedge clk);
        while (reset) @(negedge clk);
        checkOutputs();

        // Reset state of every register and HI/LO
        for (int i = 1; i < 32; i++) begin
            runCycle(1'b1, opOr, regAddrT'(i), 0, regAddrT'(i), 16'h0, 1'b0);
        end
        runCycle(1'b1, opMfhi, 0, 0, 5'd1, 16'h0, 1'b0);
        runCycle(1'b1, opMflo, 0, 0, 5'd2, 16'h0, 1'b0);

        // Random ALU traffic with forwarding
        repeat (120) randomAlu();

        // Register 0 stays zero
        runCycle(1'b1, opLui, 0, 0, 0, 16'h1234, 1'b1);
        runCycle(1'b1, opAddu, 5'd3, 5'd4, 0, 16'h0, 1'b0);
        runCycle(1'b1, opOr, 0, 0, 5'd9, 16'h0, 1'b0);
        runCycle(1'b1, opAddu, 0, 0, 5'd10, 16'h0005, 1'b1);

        // Overflow cases
        runCycle(1'b1, opLui, 0, 0, 5'd2, 16'h8000, 1'b1);
        runCycle(1'b1, opSubu, 5'd2, 0, 5'd1, 16'h0001, 1'b1);
        runCycle(1'b1, opAdd, 5'd1, 0, 5'd3, 16'h0001, 1'b1);
        runCycle(1'b1, opSub, 5'd2, 0, 5'd3, 16'h0001, 1'b1);
        runCycle(1'b1, opAdd, 5'd2, 5'd2, 5'd3, 16'h0, 1'b0);
        runCycle(1'b1, opSub, 5'd1, 5'd2, 5'd3, 16'h0, 1'b0);
        runCycle(1'b1, opOr, 5'd3, 0, 5'd4, 16'h0, 1'b0);

        // Unknown opcodes
        for (int i = 20; i < 32; i++) begin
            runCycle(1'b1, opCodeT'(i), 5'd1, 5'd2, 5'd5, 16'h0, 1'b0);
        end
        runCycle(1'b1, opOr, 5'd5, 0, 5'd6, 16'h0, 1'b0);

        repeat (20) randomAlu();

        mulDivCase(opMult, 5'd11, 5'd12);
        mulDivCase(opMultu, 5'd13, 5'd14);
        mulDivCase(opDiv, 5'd15, 5'd16);
        mulDivCase(opDivu, 5'd17, 5'd18);
        mulDivCase(opDiv, 5'd19, 5'd0);
        mulDivCase(opDivu, 5'd20, 5'd0);
        mulDivCase(opMult, 5'd2, 5'd1);
        idleCycle();
        idleCycle();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
    parameter int resetCycles = 10
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (resetCycles) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

// File: execCore.sv
`timescale 1ns/1ps
`default_nettype none

module execCore
    import execPkg::*;
#(
    parameter int dataWidth = DefaultDataWidth,
    parameter int mulLatency = DefaultMulLatency,
    parameter int divLatency = DefaultDivLatency
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 opValid,
    input  opCodeT               opCode,
    input  regAddrT              rs,
    input  regAddrT              rt,
    input  regAddrT              rd,
    input  logic [15:0]          imm,
    input  logic                 useImm,
    output logic                 busy,
    output logic                 wbValid,
    output regAddrT              wbReg,
    output logic [dataWidth-1:0] wbData,
    output logic                 excValid,
    output causeT                excCause
);

    logic [dataWidth-1:0] rsValue;
    logic [dataWidth-1:0] rtValue;
    logic [dataWidth-1:0] immExt;
    logic [dataWidth-1:0] operandB;
    logic [dataWidth-1:0] aluResult;
    logic                 aluOverflow;
    logic [dataWidth-1:0] hi;
    logic [dataWidth-1:0] lo;

    assign immExt = {{(dataWidth-16){imm[15]}}, imm};
    assign operandB = useImm ? immExt : rtValue;

    regFile #(.dataWidth(dataWidth)) regs (
        .clk(clk), .reset(reset), .rs(rs), .rt(rt),
        .rsValue(rsValue), .rtValue(rtValue),
        .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
    );

    aluUnit #(.dataWidth(dataWidth)) alu (
        .opCode(opCode), .a(rsValue), .b(operandB),
        .aluResult(aluResult), .aluOverflow(aluOverflow)
    );

    mulDivUnit #(
        .dataWidth(dataWidth), .mulLatency(mulLatency), .divLatency(divLatency)
    ) mulDiv (
        .clk(clk), .reset(reset), .opValid(opValid), .opCode(opCode),
        .a(rsValue), .b(operandB), .hi(hi), .lo(lo), .busy(busy)
    );

    writebackStage #(.dataWidth(dataWidth)) wb (
        .clk(clk), .reset(reset), .opValid(opValid), .opCode(opCode), .rd(rd),
        .aluResult(aluResult), .aluOverflow(aluOverflow), .hi(hi), .lo(lo),
        .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
        .excValid(excValid), .excCause(excCause)
    );

endmodule

`default_nettype wire

// File: writebackStage.sv
`timescale 1ns/1ps
`default_nettype none

module writebackStage
    import execPkg::*;
#(
    parameter int dataWidth = DefaultDataWidth
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 opValid,
    input  opCodeT               opCode,
    input  regAddrT              rd,
    input  logic [dataWidth-1:0] aluResult,
    input  logic                 aluOverflow,
    input  logic [dataWidth-1:0] hi,
    input  logic [dataWidth-1:0] lo,
    output logic                 wbValid,
    output regAddrT              wbReg,
    output logic [dataWidth-1:0] wbData,
    output logic                 excValid,
    output causeT                excCause
);

    logic [dataWidth-1:0] result;
    logic                 writesReg;
    logic                 reserved;
    logic                 overflow;

    always_comb begin
        result = aluResult;
        writesReg = 1'b1;
        reserved = 1'b0;
        case (opCode)
            opAdd, opAddu, opSub, opSubu, opAnd, opOr, opXor, opNor,
            opSlt, opSltu, opSllv, opSrlv, opSrav, opLui: ;
            opMult, opMultu, opDiv, opDivu: writesReg = 1'b0;
            opMfhi: result = hi;
            opMflo: result = lo;
            default: begin
                writesReg = 1'b0;
                reserved = 1'b1;
            end
        endcase
    end

    // ALU only flags ADD and SUB
    assign overflow = aluOverflow && !reserved;

    always_ff @(posedge clk) begin
        if (reset) begin
            wbValid <= 1'b0;
            excValid <= 1'b0;
        end else begin
            wbValid <= opValid && writesReg && !overflow && rd != '0;
            excValid <= opValid && (reserved || overflow);
        end
    end

    always_ff @(posedge clk) begin
        wbReg <= rd;
        wbData <= result;
        excCause <= reserved ? causeRI : causeOv;
    end

    assert property (@(posedge clk) disable iff (reset) !(wbValid && excValid));

endmodule

`default_nettype wire

// File: mulDivUnit.sv
`timescale 1ns/1ps
`default_nettype none

module mulDivUnit
    import execPkg::*;
#(
    parameter int dataWidth = DefaultDataWidth,
    parameter int mulLatency = DefaultMulLatency,
    parameter int divLatency = DefaultDivLatency
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 opValid,
    input  opCodeT               opCode,
    input  logic [dataWidth-1:0] a,
    input  logic [dataWidth-1:0] b,
    output logic [dataWidth-1:0] hi,
    output logic [dataWidth-1:0] lo,
    output logic                 busy
);

    localparam int MaxLatency = (mulLatency > divLatency) ? mulLatency : divLatency;
    localparam int CountWidth = $clog2(MaxLatency + 1);

    logic                  start;
    logic                  isDivide;
    logic [CountWidth-1:0] count;
    logic [dataWidth-1:0]  nextHi;
    logic [dataWidth-1:0]  nextLo;
    logic [dataWidth-1:0]  pendHi;
    logic [dataWidth-1:0]  pendLo;

    assign start = opValid && isMulDivOp(opCode);
    assign isDivide = opCode inside {opDiv, opDivu};
    assign busy = count != '0;

    // Result is computed at issue and held until the countdown ends
    always_comb begin
        nextHi = '0;
        nextLo = '0;
        case (opCode)
            opMult:  {nextHi, nextLo} = $signed(a) * $signed(b);
            opMultu: {nextHi, nextLo} = a * b;
            opDiv, opDivu: begin
                if (b == '0) begin
                    nextLo = '1;
                    nextHi = a;
                end else if (opCode == opDiv) begin
                    nextLo = $signed(a) / $signed(b);
                    nextHi = $signed(a) % $signed(b);
                end else begin
                    nextLo = a / b;
                    nextHi = a % b;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (start) begin
            pendHi <= nextHi;
            pendLo <= nextLo;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
            hi <= '0;
            lo <= '0;
        end else if (start) begin
            count <= isDivide ? CountWidth'(divLatency) : CountWidth'(mulLatency);
        end else if (busy) begin
            count <= count - 1'b1;
            if (count == CountWidth'(1)) begin
                hi <= pendHi;
                lo <= pendLo;
            end
        end
    end

    // Issue side must wait for busy to drop
    assert property (@(posedge clk) disable iff (reset)
        busy |-> !(opValid && (isMulDivOp(opCode) || opCode inside {opMfhi, opMflo})));

    assert property (@(posedge clk) disable iff (reset)
        not (busy [*(MaxLatency + 1)]));

endmodule

`default_nettype wire

// File: aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

module aluUnit
    import execPkg::*;
#(
    parameter int dataWidth = DefaultDataWidth
) (
    input  opCodeT               opCode,
    input  logic [dataWidth-1:0] a,
    input  logic [dataWidth-1:0] b,
    output logic [dataWidth-1:0] aluResult,
    output logic                 aluOverflow
);

    localparam int ShiftBits = $clog2(dataWidth);

    logic [dataWidth-1:0] sum;
    logic [dataWidth-1:0] diff;
    logic [ShiftBits-1:0] shamt;
    logic                 sumOv;
    logic                 diffOv;

    assign sum = a + b;
    assign diff = a - b;
    assign shamt = a[ShiftBits-1:0];

    // Same-sign inputs giving an opposite-sign result
    assign sumOv = (a[dataWidth-1] == b[dataWidth-1]) &&
                   (sum[dataWidth-1] != a[dataWidth-1]);
    assign diffOv = (a[dataWidth-1] != b[dataWidth-1]) &&
                    (diff[dataWidth-1] != a[dataWidth-1]);

    always_comb begin
        aluResult = '0;
        aluOverflow = 1'b0;
        case (opCode)
            opAdd: begin
                aluResult = sum;
                aluOverflow = sumOv;
            end
            opSub: begin
                aluResult = diff;
                aluOverflow = diffOv;
            end
            opAddu: aluResult = sum;
            opSubu: aluResult = diff;
            opAnd:  aluResult = a & b;
            opOr:   aluResult = a | b;
            opXor:  aluResult = a ^ b;
            opNor:  aluResult = ~(a | b);
            opSlt:  aluResult = {{(dataWidth-1){1'b0}}, $signed(a) < $signed(b)};
            opSltu: aluResult = {{(dataWidth-1){1'b0}}, a < b};
            opSllv: aluResult = b << shamt;
            opSrlv: aluResult = b >> shamt;
            opSrav: aluResult = $signed(b) >>> shamt;
            // b carries the sign-extended immediate
            opLui:  aluResult = b << 16;
            default: aluResult = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile
    import execPkg::*;
#(
    parameter int dataWidth = DefaultDataWidth
) (
    input  logic                 clk,
    input  logic                 reset,
    input  regAddrT              rs,
    input  regAddrT              rt,
    output logic [dataWidth-1:0] rsValue,
    output logic [dataWidth-1:0] rtValue,
    input  logic                 wbValid,
    input  regAddrT              wbReg,
    input  logic [dataWidth-1:0] wbData
);

    // Register 0 has no storage
    logic [dataWidth-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wbValid && wbReg != '0) begin
            regs[wbReg] <= wbData;
        end
    end

    // Value in writeback wins over the stored one
    function automatic logic [dataWidth-1:0] readReg(regAddrT addr);
        if (addr == '0) begin
            return '0;
        end else if (wbValid && addr == wbReg) begin
            return wbData;
        end
        return regs[addr];
    endfunction

    always_comb rsValue = readReg(rs);
    always_comb rtValue = readReg(rt);

endmodule

`default_nettype wire

// File: execPkg.sv
`default_nettype none

package execPkg;

    localparam int DefaultDataWidth = 32;
    localparam int DefaultMulLatency = 5;
    localparam int DefaultDivLatency = 12;

    // Pre-decoded operations, codes 20..31 are unassigned
    typedef enum logic [4:0] {
        opAdd   = 5'd0,
        opAddu  = 5'd1,
        opSub   = 5'd2,
        opSubu  = 5'd3,
        opAnd   = 5'd4,
        opOr    = 5'd5,
        opXor   = 5'd6,
        opNor   = 5'd7,
        opSlt   = 5'd8,
        opSltu  = 5'd9,
        opSllv  = 5'd10,
        opSrlv  = 5'd11,
        opSrav  = 5'd12,
        opLui   = 5'd13,
        opMult  = 5'd14,
        opMultu = 5'd15,
        opDiv   = 5'd16,
        opDivu  = 5'd17,
        opMfhi  = 5'd18,
        opMflo  = 5'd19
    } opCodeT;

    typedef logic [4:0] causeT;
    typedef logic [4:0] regAddrT;

    // MIPS exception codes
    localparam causeT causeRI = 5'd10;
    localparam causeT causeOv = 5'd12;

    function automatic logic isMulDivOp(opCodeT op);
        return op inside {opMult, opMultu, opDiv, opDivu};
    endfunction

endpackage

`default_nettype wire
